// ==== dbg_module.f ====
+incdir+verilog
verilog/dm_pkg.sv
verilog/dm_regs.sv
verilog/hart_ctrl.sv
verilog/dm_top.sv
tb/core_model.sv
tb/tb_dm_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the debug module testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps \
   --top-module tb_dm_top -f dbg_module.f -o sim_dm

result=$(./obj_dir/sim_dm)
echo "$result"
if grep -qx "Done: no errors" <<< "$result"; then
   exit 0
fi
exit 1

// ==== tb/core_model.sv ====
/*
  Behavioral hart for the debug module testbench.
  halt, resume and command latencies come from an LCG, 1 to 8 cycles.
  locations never written read back a pattern of type and address.
  CSR 0x7ff always fails, the access size is not modelled.
*/
`default_nettype none

module core_model (
   input  logic             clk,
   input  logic             rst,
   input  logic             dbg_halt_req,
   input  logic             dbg_resume_req,
   input  logic             dbg_core_rst_l,
   input  logic             dbg_cmd_valid,
   input  logic [31:0]      dbg_cmd_addr,
   input  logic [31:0]      dbg_cmd_wrdata,
   input  logic             dbg_cmd_write,
   input  dm_pkg::access_e  dbg_cmd_type,
   output logic [31:0]      core_dbg_rddata,
   output logic             core_dbg_cmd_done,
   output logic             core_dbg_cmd_fail,
   output logic             dec_tlu_debug_mode,
   output logic             dec_tlu_dbg_halted,
   output logic             dec_tlu_resume_ack,
   output logic             dec_tlu_mhartstart
);
   timeunit 1ns;
   timeprecision 100ps;
   import dm_pkg::*;

   logic [31:0] seed;
   logic [3:0]  halt_wait;     // 0 when no halt is pending
   logic [3:0]  resume_wait;
   logic [3:0]  cmd_wait;
   logic        cmd_pending;
   logic [33:0] cmd_key;       // {type, address}
   logic [31:0] cmd_wdata;
   logic        cmd_wr;
   logic [31:0] store [logic [33:0]];

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // contents of a location that was never written
   function automatic logic [31:0] init_word(input access_e typ, input logic [31:0] addr);
      return (addr * 32'h9e37_79b1) ^ {typ, 30'h2a5c_0f0f};
   endfunction

   function automatic logic [3:0] next_latency();
      seed = lcg_next(seed);
      return {1'b0, seed[18:16]} + 4'd1;
   endfunction

   initial begin
      seed               = 32'he68f;
      halt_wait          = 4'd0;
      resume_wait        = 4'd0;
      cmd_wait           = 4'd0;
      cmd_pending        = 1'b0;
      cmd_key            = '0;
      cmd_wdata          = '0;
      cmd_wr             = 1'b0;
      core_dbg_rddata    = '0;
      core_dbg_cmd_done  = 1'b0;
      core_dbg_cmd_fail  = 1'b0;
      dec_tlu_debug_mode = 1'b0;
      dec_tlu_dbg_halted = 1'b0;
      dec_tlu_resume_ack = 1'b0;
      dec_tlu_mhartstart = 1'b1;
      forever begin
         @(posedge clk);
         #2;
         core_dbg_rddata    = '0;
         core_dbg_cmd_done  = 1'b0;
         core_dbg_cmd_fail  = 1'b0;
         dec_tlu_resume_ack = 1'b0;
         if (rst | ~dbg_core_rst_l) begin
            // hart reset drops debug mode and all pending work
            dec_tlu_dbg_halted = 1'b0;
            dec_tlu_debug_mode = 1'b0;
            halt_wait          = 4'd0;
            resume_wait        = 4'd0;
            cmd_pending        = 1'b0;
         end else begin
            if (dbg_halt_req & ~dec_tlu_dbg_halted & (halt_wait == 4'd0))
               halt_wait = next_latency();
            else if (halt_wait == 4'd1) begin
               halt_wait          = 4'd0;
               dec_tlu_dbg_halted = 1'b1;
               dec_tlu_debug_mode = 1'b1;
            end else if (halt_wait != 4'd0)
               halt_wait = halt_wait - 4'd1;

            if (dbg_resume_req & dec_tlu_dbg_halted)
               resume_wait = next_latency();
            else if (resume_wait == 4'd1) begin
               resume_wait        = 4'd0;
               dec_tlu_dbg_halted = 1'b0;    // leaves debug mode with the ack
               dec_tlu_debug_mode = 1'b0;
               dec_tlu_resume_ack = 1'b1;
            end else if (resume_wait != 4'd0)
               resume_wait = resume_wait - 4'd1;

            if (dbg_cmd_valid) begin
               cmd_pending = 1'b1;
               cmd_key     = {dbg_cmd_type, dbg_cmd_addr};
               cmd_wdata   = dbg_cmd_wrdata;
               cmd_wr      = dbg_cmd_write;
               cmd_wait    = next_latency();
            end else if (cmd_pending) begin
               cmd_wait = cmd_wait - 4'd1;
               if (cmd_wait == 4'd0) begin
                  cmd_pending       = 1'b0;
                  core_dbg_cmd_done = 1'b1;
                  if (cmd_key == {ACC_CSR, 32'h0000_07ff})
                     core_dbg_cmd_fail = 1'b1;   // unimplemented CSR
                  else if (cmd_wr)
                     store[cmd_key] = cmd_wdata;
                  else if (store.exists(cmd_key))
                     core_dbg_rddata = store[cmd_key];
                  else
                     core_dbg_rddata = init_word(access_e'(cmd_key[33:32]), cmd_key[31:0]);
               end
            end
         end
      end
   end

endmodule

`default_nettype wire

// ==== tb/tb_dm_top.sv ====
/*
  Testbench of the debug module with a behavioral hart.
  DMI inputs change 2 ns after the rising edge, read data is taken one
  cycle after the access. the run is cut off after 5000 cycles.
*/
`default_nettype none
`include "dm_cfg.svh"

module tb_dm_top;
   timeunit 1ns;
   timeprecision 100ps;
   import dm_pkg::*;

   localparam int MAX_CYCLES = 5000;    // about 12 polls of at most 100 reads, plus ~40 accesses
   localparam int POLL_LIMIT = 100;
   localparam logic [31:0] CMD_REG_RD = 32'h0022_0000;    // 32 bit, transfer
   localparam logic [31:0] CMD_MEM_RD = 32'h0220_0000;
   localparam logic [31:0] CMD_MEM_WR = 32'h0221_0000;

   logic clk;
   logic rst;
   logic dmi_reg_en;
   logic dmi_reg_wr_en;
   logic [6:0] dmi_reg_addr;
   logic [31:0] dmi_reg_wdata;
   logic [31:0] dmi_reg_rdata;
   logic [31:0] dbg_cmd_addr;
   logic [31:0] dbg_cmd_wrdata;
   logic dbg_cmd_valid;
   logic dbg_cmd_write;
   access_e dbg_cmd_type;
   logic [1:0] dbg_cmd_size;
   logic dbg_core_rst_l;
   logic dbg_halt_req;
   logic dbg_resume_req;
   logic [31:0] core_dbg_rddata;
   logic core_dbg_cmd_done;
   logic core_dbg_cmd_fail;
   logic dec_tlu_debug_mode;
   logic dec_tlu_dbg_halted;
   logic dec_tlu_resume_ack;
   logic dec_tlu_mhartstart;
   logic [31:0] rd;
   logic [1:0] cmd_size_seen = 2'b00;
   int errors;
   int checks;
   int cycles = 0;

   dm_top i_dm_top (.*);
   core_model i_core (.*);

   // ******************************
   // reference values
   // ******************************
   function automatic logic [31:0] status_word(input logic hlt, input logic rack,
                                               input logic hrst);
      logic [31:0] w;
      w        = 32'h0;
      w[3:0]   = 4'd2;        // version 0.13
      w[7]     = 1'b1;        // authenticated
      w[9:8]   = {2{hlt}};
      w[17:16] = {2{rack}};
      w[19:18] = {2{hrst}};
      return w;
   endfunction

   function automatic logic [31:0] ref_word(input access_e typ, input logic [31:0] addr);
      return (addr * 32'h9e37_79b1) ^ {typ, 30'h2a5c_0f0f};   // hart's reset contents
   endfunction

   task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, exp);
      end
   endtask

   task automatic check_cmderr(input cmderr_e got, input cmderr_e exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("[ERROR] cmderr: got 0x%0h, expected 0x%0h", got, exp);
      end
   endtask

   // ******************************
   // DMI access
   // ******************************
   task automatic dmi_write(input logic [6:0] addr, input logic [31:0] data);
      dmi_reg_en    = 1'b1;
      dmi_reg_wr_en = 1'b1;
      dmi_reg_addr  = addr;
      dmi_reg_wdata = data;
      @(posedge clk);
      #2;
      dmi_reg_en    = 1'b0;
      dmi_reg_wr_en = 1'b0;
   endtask

   task automatic dmi_read(input logic [6:0] addr, output logic [31:0] data);
      dmi_reg_en   = 1'b1;
      dmi_reg_addr = addr;
      @(posedge clk);
      #2;
      dmi_reg_en = 1'b0;
      data       = dmi_reg_rdata;
   endtask

   task automatic poll(input logic [6:0] addr, input logic [31:0] mask,
                       input logic [31:0] want, input string what);
      logic [31:0] v;
      int          n;
      n = 0;
      dmi_read(addr, v);
      while (((v & mask) != want) && (n < POLL_LIMIT)) begin
         dmi_read(addr, v);
         n++;
      end
      if ((v & mask) != want) begin
         errors++;
         $display("gave up waiting for %s after %0d reads", what, POLL_LIMIT);
      end
   endtask

   // one abstract command, cmderr checked and cleared once busy drops
   task automatic run_command(input logic [31:0] cmd, input cmderr_e exp_err);
      logic [31:0] v;
      dmi_write(`DM_ADDR_COMMAND, cmd);
      poll(`DM_ADDR_ABSTRACTCS, 32'h0000_1000, 32'h0, "abstract command to finish");
      dmi_read(`DM_ADDR_ABSTRACTCS, v);
      check_cmderr(cmderr_e'(v[10:8]), exp_err);
      if (exp_err != NONE)
         dmi_write(`DM_ADDR_ABSTRACTCS, 32'h0000_0700);
   endtask

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycles == MAX_CYCLES) begin
         $display("timeout: run did not end within %0d cycles", MAX_CYCLES);
         $display("Done: errors found");
         $finish;
      end
   end

   // size field of the last command handed to the hart
   always @(posedge clk) begin
      if (dbg_cmd_valid)
         cmd_size_seen <= dbg_cmd_size;
   end

   initial begin
      rst           = 1'b1;
      dmi_reg_en    = 1'b0;
      dmi_reg_wr_en = 1'b0;
      dmi_reg_addr  = 7'h0;
      dmi_reg_wdata = 32'h0;
      errors        = 0;
      checks        = 0;
      repeat (8) @(posedge clk);
      #2;
      rst = 1'b0;

      // activate the DM, idle status
      dmi_write(`DM_ADDR_DMCONTROL, 32'h0000_0001);
      dmi_read(`DM_ADDR_DMSTATUS, rd);
      check_word("dmstatus", rd, status_word(1'b0, 1'b0, 1'b0));
      dmi_read(`DM_ADDR_ABSTRACTCS, rd);
      check_word("abstractcs", rd, 32'h0000_0002);

      // halt, with a command written before the hart gets there
      dmi_write(`DM_ADDR_DMCONTROL, 32'h8000_0001);
      dmi_write(`DM_ADDR_COMMAND, CMD_REG_RD | 32'h1005);
      poll(`DM_ADDR_DMSTATUS, 32'h0000_0300, 32'h0000_0300, "hart to halt");
      dmi_read(`DM_ADDR_ABSTRACTCS, rd);
      check_cmderr(cmderr_e'(rd[10:8]), HALT_RESUME);
      dmi_write(`DM_ADDR_ABSTRACTCS, 32'h0000_0700);
      dmi_read(`DM_ADDR_ABSTRACTCS, rd);
      check_cmderr(cmderr_e'(rd[10:8]), NONE);

      // ******************************
      // register and memory commands
      // ******************************
      run_command(CMD_REG_RD | 32'h1005, NONE);    // x5
      dmi_read(`DM_ADDR_DATA0, rd);
      check_word("data0", rd, ref_word(ACC_GPR, 32'h0000_0005));
      run_command(CMD_REG_RD | 32'h0300, NONE);    // mstatus
      dmi_read(`DM_ADDR_DATA0, rd);
      check_word("data0", rd, ref_word(ACC_CSR, 32'h0000_0300));
      run_command(CMD_REG_RD | 32'h07ff, EXCEPTION);

      dmi_write(`DM_ADDR_DATA1, 32'h2000_0104);
      dmi_write(`DM_ADDR_DATA0, 32'hcafe_f00d);
      run_command(CMD_MEM_WR, NONE);
      dmi_write(`DM_ADDR_DATA0, 32'h0);            // so the read must refill it
      run_command(CMD_MEM_RD, NONE);
      dmi_read(`DM_ADDR_DATA0, rd);
      check_word("data0", rd, 32'hcafe_f00d);
      check_word("dbg_cmd_size", {30'h0, cmd_size_seen}, 32'h2);
      run_command(32'h0210_0000, NONE);            // half word, aligned
      check_word("dbg_cmd_size", {30'h0, cmd_size_seen}, 32'h1);
      dmi_write(`DM_ADDR_DATA1, 32'h2000_0105);
      run_command(32'h0210_0000, UNALIGNED);       // half word, odd address
      run_command(32'h0100_0000, NOT_SUPPORTED);   // quick access

      // second command lands while the first is busy
      dmi_write(`DM_ADDR_COMMAND, CMD_REG_RD | 32'h1006);
      run_command(CMD_REG_RD | 32'h1006, BUSY);
      dmi_read(`DM_ADDR_DATA0, rd);
      check_word("data0", rd, ref_word(ACC_GPR, 32'h0000_0006));

      // resume, then reset the hart through ndmreset
      dmi_write(`DM_ADDR_DMCONTROL, 32'h4000_0001);
      poll(`DM_ADDR_DMSTATUS, 32'h0003_0000, 32'h0003_0000, "resume ack");
      dmi_read(`DM_ADDR_DMSTATUS, rd);
      check_word("dmstatus", rd, status_word(1'b0, 1'b1, 1'b0));
      dmi_write(`DM_ADDR_DMCONTROL, 32'h0000_0003);
      check_word("dbg_core_rst_l", {31'h0, dbg_core_rst_l}, 32'h0);
      dmi_read(`DM_ADDR_DMSTATUS, rd);
      check_word("dmstatus.havereset", rd & 32'h000c_0000, 32'h000c_0000);
      dmi_write(`DM_ADDR_DMCONTROL, 32'h1000_0001);
      check_word("dbg_core_rst_l", {31'h0, dbg_core_rst_l}, 32'h1);
      dmi_read(`DM_ADDR_DMSTATUS, rd);
      check_word("dmstatus.havereset", rd & 32'h000c_0300, 32'h0);

      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("Done: no errors");
      else
         $display("Done: errors found");
      $finish;
   end

endmodule

`default_nettype wire

// ==== verilog/dm_cfg.svh ====
/*
  DMI register map and field positions of the debug module.
  single hart only, so the all/any status pairs share one source bit
  and the "all" bit always sits one above the "any" bit.
*/
`ifndef DM_CFG_SVH
`define DM_CFG_SVH

// DMI register addresses
`define DM_ADDR_DATA0          7'h04
`define DM_ADDR_DATA1          7'h05
`define DM_ADDR_DMCONTROL      7'h10
`define DM_ADDR_DMSTATUS       7'h11
`define DM_ADDR_ABSTRACTCS     7'h16
`define DM_ADDR_COMMAND        7'h17

`define DM_VERSION             4'd2    // debug spec 0.13
`define DM_DATACOUNT           4'd2

// cmdtype codes
`define DM_CMDTYPE_REG         8'h00
`define DM_CMDTYPE_MEM         8'h02

// dmcontrol
`define DM_CTRL_HALTREQ        31
`define DM_CTRL_RESUMEREQ      30
`define DM_CTRL_ACKHAVERESET   28
`define DM_CTRL_NDMRESET       1
`define DM_CTRL_DMACTIVE       0

// dmstatus, lower bit of each all/any pair
`define DM_STAT_ANYHAVERESET   18
`define DM_STAT_ANYRESUMEACK   16
`define DM_STAT_ANYUNAVAIL     12
`define DM_STAT_ANYHALTED      8
`define DM_STAT_AUTHENTICATED  7

// abstractcs
`define DM_ACS_BUSY            12
`define DM_ACS_CMDERR_LO       8

// command
`define DM_CMD_TYPE_LO         24
`define DM_CMD_SIZE_LO         20
`define DM_CMD_WRITE           16

`endif

// ==== verilog/dm_pkg.sv ====
/*
  Shared types of the debug module.
  cmderr codes follow the debug spec abstractcs encoding.
*/
`default_nettype none
`include "dm_cfg.svh"

package dm_pkg;

   // hart control FSM
   typedef enum logic [2:0] {
      IDLE      = 3'd0,
      HALTING   = 3'd1,
      HALTED    = 3'd2,
      CMD_START = 3'd3,
      CMD_WAIT  = 3'd4,
      CMD_DONE  = 3'd5,
      RESUMING  = 3'd6
   } hart_state_e;

   // cmdtype field of the command register
   typedef enum logic [7:0] {
      CMDTYPE_REG = `DM_CMDTYPE_REG,
      CMDTYPE_MEM = `DM_CMDTYPE_MEM
   } cmdtype_e;

   typedef enum logic [2:0] {
      NONE          = 3'd0,
      BUSY          = 3'd1,
      NOT_SUPPORTED = 3'd2,
      EXCEPTION     = 3'd3,
      HALT_RESUME   = 3'd4,
      UNALIGNED     = 3'd7
   } cmderr_e;

   // core access target, drives dbg_cmd_type
   typedef enum logic [1:0] {
      ACC_GPR = 2'd0,
      ACC_CSR = 2'd1,
      ACC_MEM = 2'd2
   } access_e;

endpackage

`default_nettype wire

// ==== verilog/dm_regs.sv ====
/*
  DMI visible registers of the debug module.
  dmactive is cleared by rst only, all other state also by dm_rst.
  command, data0 and data1 accept writes only while the hart FSM is HALTED.
  read data is registered on each access and holds until the next one.
*/
`default_nettype none
`include "dm_cfg.svh"

module dm_regs (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 dm_rst,
   input  logic                 dmi_reg_en,
   input  logic                 dmi_reg_wr_en,
   input  logic [6:0]           dmi_reg_addr,
   input  logic [31:0]          dmi_reg_wdata,
   input  dm_pkg::hart_state_e  hart_state,
   input  logic                 halted,
   input  logic                 resumeack,
   input  logic                 havereset,
   input  logic                 unavailable,
   input  logic                 busy,
   input  logic                 data0_capture,
   input  logic [31:0]          core_dbg_rddata,
   input  logic                 core_dbg_cmd_done,
   input  logic                 core_dbg_cmd_fail,
   output logic [31:0]          dmi_reg_rdata,
   output logic                 dmactive,
   output logic                 haltreq,
   output logic                 resumereq,
   output logic                 ndmreset,
   output logic                 dmcontrol_wr,
   output logic                 command_wr,
   output dm_pkg::cmderr_e      cmderr,
   output logic [31:0]          command,
   output logic [31:0]          data0,
   output logic [31:0]          data1,
   output logic                 ackhavereset_wr,
   output logic                 havereset_set
);
   import dm_pkg::*;

   logic        reg_wr;
   logic        in_halted;
   logic        dmcontrol_wen;
   logic        cmd_access;      // any command write, accepted or not
   logic        acs_access;
   logic        data_access;
   logic        data0_wen;
   logic        data1_wen;
   logic [7:0]  wr_cmdtype;
   logic [2:0]  wr_size;
   logic        wr_unaligned;
   cmderr_e     cmderr_d;
   logic [31:0] dmcontrol;
   logic [31:0] dmstatus;
   logic [31:0] abstractcs;
   logic [31:0] rdata_d;

   // ******************************
   // write decode
   // ******************************
   assign reg_wr        = dmi_reg_en & dmi_reg_wr_en;
   assign in_halted     = (hart_state == HALTED);
   assign dmcontrol_wen = reg_wr & (dmi_reg_addr == `DM_ADDR_DMCONTROL);
   assign cmd_access    = reg_wr & (dmi_reg_addr == `DM_ADDR_COMMAND);
   assign acs_access    = reg_wr & (dmi_reg_addr == `DM_ADDR_ABSTRACTCS);
   assign data_access   = dmi_reg_en & ((dmi_reg_addr == `DM_ADDR_DATA0) |
                                        (dmi_reg_addr == `DM_ADDR_DATA1));
   assign command_wr    = cmd_access & in_halted;
   assign data0_wen     = reg_wr & (dmi_reg_addr == `DM_ADDR_DATA0) & in_halted;
   assign data1_wen     = reg_wr & (dmi_reg_addr == `DM_ADDR_DATA1) & in_halted;

   assign ackhavereset_wr = dmcontrol_wen & dmi_reg_wdata[`DM_CTRL_ACKHAVERESET];
   assign havereset_set   = dmcontrol_wen & dmi_reg_wdata[`DM_CTRL_NDMRESET];

   // dmactive survives dm_rst, otherwise the DM could never leave reset
   always_ff @(posedge clk) begin
      if (rst)
         dmactive <= 1'b0;
      else if (dmcontrol_wen)
         dmactive <= dmi_reg_wdata[`DM_CTRL_DMACTIVE];
   end

   always_ff @(posedge clk) begin
      if (dm_rst) begin
         haltreq      <= 1'b0;
         resumereq    <= 1'b0;
         ndmreset     <= 1'b0;
         dmcontrol_wr <= 1'b0;
      end else begin
         dmcontrol_wr <= dmcontrol_wen;     // lines up with the new field values
         if (dmcontrol_wen) begin
            haltreq   <= dmi_reg_wdata[`DM_CTRL_HALTREQ];
            resumereq <= dmi_reg_wdata[`DM_CTRL_RESUMEREQ];
            ndmreset  <= dmi_reg_wdata[`DM_CTRL_NDMRESET];
         end
      end
   end

   // ******************************
   // command and data registers
   // ******************************
   assign wr_cmdtype = dmi_reg_wdata[`DM_CMD_TYPE_LO +: 8];
   assign wr_size    = dmi_reg_wdata[`DM_CMD_SIZE_LO +: 3];

   always_ff @(posedge clk) begin
      if (dm_rst) begin
         command <= '0;
         data0   <= '0;
         data1   <= '0;
      end else begin
         // aamvirtual, postincrement and postexec are not kept
         if (command_wr)
            command <= {wr_cmdtype, 1'b0, wr_size, 3'b000, dmi_reg_wdata[16:0]};
         if (data0_wen)
            data0 <= dmi_reg_wdata;
         else if (data0_capture & ~core_dbg_cmd_fail)
            data0 <= core_dbg_rddata;         // abstract read result
         if (data1_wen)
            data1 <= dmi_reg_wdata;
      end
   end

   // ******************************
   // cmderr
   // ******************************
   // sizes above 32 bit are never aligned for a word memory
   assign wr_unaligned = wr_size[2] | (wr_size == 3'd3) |
                         ((wr_size == 3'd1) & data1[0]) |
                         ((wr_size == 3'd2) & (|data1[1:0]));

   // first cause wins, W1C and hold only apply when nothing else fires
   always_comb begin
      cmderr_d = cmderr;
      if (busy & (cmd_access | acs_access | data_access))
         cmderr_d = BUSY;
      else if (cmd_access & (wr_cmdtype != CMDTYPE_REG) & (wr_cmdtype != CMDTYPE_MEM))
         cmderr_d = NOT_SUPPORTED;
      else if (core_dbg_cmd_done & core_dbg_cmd_fail)
         cmderr_d = EXCEPTION;
      else if (cmd_access & ~halted)
         cmderr_d = HALT_RESUME;
      else if (cmd_access & (wr_cmdtype == CMDTYPE_MEM) & wr_unaligned)
         cmderr_d = UNALIGNED;
      else if (acs_access)
         cmderr_d = cmderr_e'(cmderr & ~dmi_reg_wdata[`DM_ACS_CMDERR_LO +: 3]);
   end

   always_ff @(posedge clk) begin
      if (dm_rst)
         cmderr <= NONE;
      else
         cmderr <= cmderr_d;
   end

   // ******************************
   // read side
   // ******************************
   always_comb begin
      dmcontrol                       = '0;
      dmcontrol[`DM_CTRL_HALTREQ]     = haltreq;
      dmcontrol[`DM_CTRL_RESUMEREQ]   = resumereq;
      dmcontrol[`DM_CTRL_NDMRESET]    = ndmreset;
      dmcontrol[`DM_CTRL_DMACTIVE]    = dmactive;

      dmstatus                              = '0;
      dmstatus[`DM_STAT_ANYHAVERESET +: 2]  = {2{havereset}};
      dmstatus[`DM_STAT_ANYRESUMEACK +: 2]  = {2{resumeack}};
      dmstatus[`DM_STAT_ANYUNAVAIL +: 2]    = {2{unavailable}};
      dmstatus[`DM_STAT_ANYHALTED +: 2]     = {2{halted}};
      dmstatus[`DM_STAT_AUTHENTICATED]      = 1'b1;   // no authentication
      dmstatus[3:0]                         = `DM_VERSION;

      abstractcs                          = '0;
      abstractcs[`DM_ACS_BUSY]            = busy;
      abstractcs[`DM_ACS_CMDERR_LO +: 3]  = cmderr;
      abstractcs[3:0]                     = `DM_DATACOUNT;
   end

   always_comb begin
      case (dmi_reg_addr)
         `DM_ADDR_DATA0:      rdata_d = data0;
         `DM_ADDR_DATA1:      rdata_d = data1;
         `DM_ADDR_DMCONTROL:  rdata_d = dmcontrol;
         `DM_ADDR_DMSTATUS:   rdata_d = dmstatus;
         `DM_ADDR_ABSTRACTCS: rdata_d = abstractcs;
         `DM_ADDR_COMMAND:    rdata_d = command;
         default:             rdata_d = '0;      // unimplemented reads as zero
      endcase
   end

   always_ff @(posedge clk) begin
      if (dm_rst)
         dmi_reg_rdata <= '0;
      else if (dmi_reg_en)
         dmi_reg_rdata <= rdata_d;
   end

endmodule

`default_nettype wire

// ==== verilog/dm_top.sv ====
/*
  Debug module top for a single hart.
  the whole DM except dmactive stays in reset until dmactive is written 1.
  dbg_core_rst_l follows ndmreset directly.
*/
`default_nettype none

module dm_top (
   input  logic             clk,
   input  logic             rst,
   input  logic             dmi_reg_en,
   input  logic             dmi_reg_wr_en,
   input  logic [6:0]       dmi_reg_addr,
   input  logic [31:0]      dmi_reg_wdata,
   input  logic [31:0]      core_dbg_rddata,
   input  logic             core_dbg_cmd_done,
   input  logic             core_dbg_cmd_fail,
   input  logic             dec_tlu_debug_mode,
   input  logic             dec_tlu_dbg_halted,
   input  logic             dec_tlu_resume_ack,
   input  logic             dec_tlu_mhartstart,
   output logic [31:0]      dmi_reg_rdata,
   output logic [31:0]      dbg_cmd_addr,
   output logic [31:0]      dbg_cmd_wrdata,
   output logic             dbg_cmd_valid,
   output logic             dbg_cmd_write,
   output dm_pkg::access_e  dbg_cmd_type,
   output logic [1:0]       dbg_cmd_size,
   output logic             dbg_core_rst_l,
   output logic             dbg_halt_req,
   output logic             dbg_resume_req
);
   import dm_pkg::*;

   logic        dm_rst;
   logic        dmactive;
   logic        mhartstart_q;
   logic        haltreq;
   logic        resumereq;
   logic        ndmreset;
   logic        dmcontrol_wr;
   logic        command_wr;
   logic        ackhavereset_wr;
   logic        havereset_set;
   logic        halted;
   logic        resumeack;
   logic        havereset;
   logic        unavailable;
   logic        busy;
   logic        data0_capture;
   cmderr_e     cmderr;
   hart_state_e hart_state;
   logic [31:0] command;
   logic [31:0] data0;
   logic [31:0] data1;

   assign dm_rst         = rst | ~dmactive;
   assign dbg_core_rst_l = ~ndmreset;

   always_ff @(posedge clk) begin
      if (rst)
         mhartstart_q <= 1'b0;
      else
         mhartstart_q <= dec_tlu_mhartstart;
   end

   dm_regs i_dm_regs (
      .clk               (clk),
      .rst               (rst),
      .dm_rst            (dm_rst),
      .dmi_reg_en        (dmi_reg_en),
      .dmi_reg_wr_en     (dmi_reg_wr_en),
      .dmi_reg_addr      (dmi_reg_addr),
      .dmi_reg_wdata     (dmi_reg_wdata),
      .hart_state        (hart_state),
      .halted            (halted),
      .resumeack         (resumeack),
      .havereset         (havereset),
      .unavailable       (unavailable),
      .busy              (busy),
      .data0_capture     (data0_capture),
      .core_dbg_rddata   (core_dbg_rddata),
      .core_dbg_cmd_done (core_dbg_cmd_done),
      .core_dbg_cmd_fail (core_dbg_cmd_fail),
      .dmi_reg_rdata     (dmi_reg_rdata),
      .dmactive          (dmactive),
      .haltreq           (haltreq),
      .resumereq         (resumereq),
      .ndmreset          (ndmreset),
      .dmcontrol_wr      (dmcontrol_wr),
      .command_wr        (command_wr),
      .cmderr            (cmderr),
      .command           (command),
      .data0             (data0),
      .data1             (data1),
      .ackhavereset_wr   (ackhavereset_wr),
      .havereset_set     (havereset_set)
   );

   hart_ctrl i_hart_ctrl (
      .clk                (clk),
      .dm_rst             (dm_rst),
      .haltreq            (haltreq),
      .resumereq          (resumereq),
      .ndmreset           (ndmreset),
      .dmcontrol_wr       (dmcontrol_wr),
      .command_wr         (command_wr),
      .cmderr             (cmderr),
      .command            (command),
      .data0              (data0),
      .data1              (data1),
      .ackhavereset_wr    (ackhavereset_wr),
      .havereset_set      (havereset_set),
      .mhartstart_q       (mhartstart_q),
      .dec_tlu_debug_mode (dec_tlu_debug_mode),
      .dec_tlu_dbg_halted (dec_tlu_dbg_halted),
      .dec_tlu_resume_ack (dec_tlu_resume_ack),
      .core_dbg_cmd_done  (core_dbg_cmd_done),
      .hart_state         (hart_state),
      .halted             (halted),
      .resumeack          (resumeack),
      .havereset          (havereset),
      .unavailable        (unavailable),
      .busy               (busy),
      .data0_capture      (data0_capture),
      .dbg_halt_req       (dbg_halt_req),
      .dbg_resume_req     (dbg_resume_req),
      .dbg_cmd_addr       (dbg_cmd_addr),
      .dbg_cmd_wrdata     (dbg_cmd_wrdata),
      .dbg_cmd_valid      (dbg_cmd_valid),
      .dbg_cmd_write      (dbg_cmd_write),
      .dbg_cmd_type       (dbg_cmd_type),
      .dbg_cmd_size       (dbg_cmd_size)
   );

endmodule

`default_nettype wire

// ==== verilog/hart_ctrl.sv ====
/*
  Halt, resume and abstract command control for a single hart.
  dbg_cmd_valid is a one cycle pulse, the command fields hold until done.
  memory accesses are word addressed from data1, register accesses use
  the low 12 bits of regno.
*/
`default_nettype none
`include "dm_cfg.svh"

module hart_ctrl (
   input  logic                 clk,
   input  logic                 dm_rst,
   input  logic                 haltreq,
   input  logic                 resumereq,
   input  logic                 ndmreset,
   input  logic                 dmcontrol_wr,
   input  logic                 command_wr,
   input  dm_pkg::cmderr_e      cmderr,
   input  logic [31:0]          command,
   input  logic [31:0]          data0,
   input  logic [31:0]          data1,
   input  logic                 ackhavereset_wr,
   input  logic                 havereset_set,
   input  logic                 mhartstart_q,
   input  logic                 dec_tlu_debug_mode,
   input  logic                 dec_tlu_dbg_halted,
   input  logic                 dec_tlu_resume_ack,
   input  logic                 core_dbg_cmd_done,
   output dm_pkg::hart_state_e  hart_state,
   output logic                 halted,
   output logic                 resumeack,
   output logic                 havereset,
   output logic                 unavailable,
   output logic                 busy,
   output logic                 data0_capture,
   output logic                 dbg_halt_req,
   output logic                 dbg_resume_req,
   output logic [31:0]          dbg_cmd_addr,
   output logic [31:0]          dbg_cmd_wrdata,
   output logic                 dbg_cmd_valid,
   output logic                 dbg_cmd_write,
   output dm_pkg::access_e      dbg_cmd_type,
   output logic [1:0]           dbg_cmd_size
);
   import dm_pkg::*;

   hart_state_e state_d;
   logic        busy_set;
   logic        busy_clr;
   logic        resume_done;
   logic        cmd_is_mem;

   // ******************************
   // hart FSM
   // ******************************
   always_comb begin
      state_d        = hart_state;
      busy_set       = 1'b0;
      busy_clr       = 1'b0;
      dbg_halt_req   = dmcontrol_wr & haltreq;   // pulse on every haltreq write
      dbg_resume_req = 1'b0;
      case (hart_state)
         IDLE: begin
            dbg_halt_req = dbg_halt_req | (haltreq & mhartstart_q);
            if (((haltreq & ~dec_tlu_debug_mode) | halted) & ~ndmreset & mhartstart_q) begin
               if (halted)
                  state_d = HALTED;
               else
                  state_d = HALTING;
            end
         end
         HALTING: begin
            if (halted)
               state_d = HALTED;
         end
         HALTED: begin
            // hart left debug mode on its own or is being reset
            if (~halted | ndmreset) begin
               if (haltreq)
                  state_d = HALTING;
               else
                  state_d = IDLE;
            end else if (command_wr) begin
               state_d  = CMD_START;
               busy_set = 1'b1;
            end else if (dmcontrol_wr & resumereq & ~haltreq) begin
               state_d        = RESUMING;
               dbg_resume_req = 1'b1;
            end
         end
         CMD_START: begin
            if (cmderr != NONE)
               state_d = CMD_DONE;    // error already flagged, skip the core
            else
               state_d = CMD_WAIT;
         end
         CMD_WAIT: begin
            if (core_dbg_cmd_done)
               state_d = CMD_DONE;
         end
         CMD_DONE: begin
            state_d  = HALTED;
            busy_clr = 1'b1;
         end
         RESUMING: begin
            if (resumeack)
               state_d = IDLE;
         end
         default: state_d = IDLE;
      endcase
   end

   assign resume_done = (hart_state == RESUMING) & dec_tlu_resume_ack;

   always_ff @(posedge clk) begin
      if (dm_rst) begin
         hart_state <= IDLE;
         halted     <= 1'b0;
         resumeack  <= 1'b0;
         havereset  <= 1'b0;
         busy       <= 1'b0;
      end else begin
         hart_state <= state_d;
         halted     <= dec_tlu_dbg_halted;
         if (resume_done)
            resumeack <= 1'b1;
         else if (dbg_resume_req | ~resumereq)
            resumeack <= 1'b0;       // new resume or resumereq dropped
         if (ackhavereset_wr)
            havereset <= 1'b0;
         else if (havereset_set)
            havereset <= 1'b1;
         if (busy_set)
            busy <= 1'b1;
         else if (busy_clr)
            busy <= 1'b0;
      end
   end

   assign unavailable = ~mhartstart_q;

   // ******************************
   // core command interface
   // ******************************
   assign cmd_is_mem     = (command[`DM_CMD_TYPE_LO +: 8] == CMDTYPE_MEM);
   assign dbg_cmd_addr   = cmd_is_mem ? {data1[31:2], 2'b00} : {20'b0, command[11:0]};
   assign dbg_cmd_wrdata = data0;
   assign dbg_cmd_write  = command[`DM_CMD_WRITE];
   assign dbg_cmd_size   = command[`DM_CMD_SIZE_LO +: 2];
   assign dbg_cmd_valid  = (hart_state == CMD_START) & (cmderr == NONE);
   assign data0_capture  = core_dbg_cmd_done & (hart_state == CMD_WAIT) &
                           ~command[`DM_CMD_WRITE];

   // regno 0x0000-0x0fff are CSRs, the rest go to the GPR file
   always_comb begin
      if (cmd_is_mem)
         dbg_cmd_type = ACC_MEM;
      else if (command[15:12] == 4'h0)
         dbg_cmd_type = ACC_CSR;
      else
         dbg_cmd_type = ACC_GPR;
   end

endmodule

`default_nettype wire
